// File: vlog.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ex_operand_decode.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_muldiv.sv
verilog/ex_result_merge.sv
verilog/ex_stage_top.sv
verification/ex_stage_chk.sv
verification/ex_stage_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = ex_stage_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ex_stage_tb.sv
module ex_stage_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int MUL_STAGES = 3;
    localparam int NUM_INSTR  = 400;
    localparam int TIMEOUT    = 100;

    logic   clk;
    logic   rst_i;
    issue_t issue_i;
    logic   stall_i;
    exec_t  exec_o;
    logic   busy_o;

    int mismatches;
    int timeouts;

    ex_stage_top #(
        .MUL_STAGES (MUL_STAGES)
    ) u_dut (
        .clk     (clk),
        .rst_i   (rst_i),
        .issue_i (issue_i),
        .stall_i (stall_i),
        .exec_o  (exec_o),
        .busy_o  (busy_o)
    );

    always #2 clk = ~clk;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ctl(input string what, input ctl_t got, input ctl_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_exc(input string what, input exc_t got, input exc_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_hilo(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // reference model of the combinational part of the stage
    function automatic exec_t model_exec(input issue_t ins);
        exec_t  e;
        word_t  a;
        word_t  b;
        word_t  addr;
        logic   cond;
        logic   misal;
        longint wide;
        e = '0;
        // operand sources
        a = ins.ctl.shamt_valid ? {27'b0, ins.raw_instr[10:6]} : ins.rd1;
        if (!ins.ctl.alusrc_imm) begin
            b = ins.rd2;
        end else if (ins.ctl.zeroext) begin
            b = {16'b0, ins.raw_instr[15:0]};
        end else begin
            b = {{16{ins.raw_instr[15]}}, ins.raw_instr[15:0]};
        end
        case (ins.ctl.alu_op)
            ADD, ADDU: e.alu_out = a + b;
            SUB, SUBU: e.alu_out = a - b;
            AND:       e.alu_out = a & b;
            OR:        e.alu_out = a | b;
            XOR:       e.alu_out = a ^ b;
            NOR:       e.alu_out = ~(a | b);
            SLT:       e.alu_out = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      e.alu_out = (a < b) ? 32'd1 : 32'd0;
            SLL:       e.alu_out = b << a[4:0];
            SRL:       e.alu_out = b >> a[4:0];
            SRA:       e.alu_out = word_t'($signed(b) >>> a[4:0]);
            LUI:       e.alu_out = {b[15:0], 16'h0};
            default:   e.alu_out = '0;
        endcase
        // exact signed result vs the 32-bit one
        wide = 0;
        if (ins.ctl.alu_op == ADD) begin
            wide = longint'($signed(a)) + longint'($signed(b));
        end else if (ins.ctl.alu_op == SUB) begin
            wide = longint'($signed(a)) - longint'($signed(b));
        end
        e.exc.overflow = ins.valid && (ins.ctl.alu_op inside {ADD, SUB})
                      && (wide != longint'($signed(e.alu_out)));
        if (ins.ctl.is_link) begin
            e.alu_out = ins.pc + 32'd8;
        end
        e.valid = ins.valid;
        e.pc    = ins.pc;
        e.srcb  = ins.rd2;
        e.ctl   = ins.ctl;
        // branch condition on register values
        case (ins.ctl.branch_type)
            BEQ:     cond = ins.rd1 == ins.rd2;
            BNE:     cond = ins.rd1 != ins.rd2;
            BGEZ:    cond = $signed(ins.rd1) >= 0;
            BGTZ:    cond = $signed(ins.rd1) > 0;
            BLEZ:    cond = $signed(ins.rd1) <= 0;
            BLTZ:    cond = $signed(ins.rd1) < 0;
            default: cond = 1'b0;
        endcase
        // each way of leaving the fetched path, with its own target
        if (ins.ctl.branch && cond && !ins.pre_b) begin
            e.redirect = ins.valid;
            e.target   = ins.pc + 32'd4 + {{14{ins.raw_instr[15]}}, ins.raw_instr[15:0], 2'b00};
        end else if (ins.ctl.branch && !cond && ins.pre_b) begin
            // resume after the delay slot
            e.redirect = ins.valid;
            e.target   = ins.pc + 32'd8;
        end else if (ins.ctl.jr && !ins.pre_b) begin
            e.redirect = ins.valid;
            e.target   = ins.rd1;
        end else if (ins.ctl.jump && !ins.pre_b) begin
            e.redirect = ins.valid;
            e.target   = {ins.pc[31:28] + {3'b0, &ins.pc[27:2]}, ins.raw_instr[25:0], 2'b00};
        end
        // alignment of the effective address
        addr = a + b;
        case (ins.ctl.msize)
            MSIZE2:  misal = (addr % 2) != 0;
            MSIZE4:  misal = (addr % 4) != 0;
            default: misal = 1'b0;
        endcase
        e.exc.adel = ins.valid && ins.ctl.memtoreg && misal;
        e.exc.ades = ins.valid && ins.ctl.memwrite && misal;
        if (e.exc.adel) begin
            e.ctl.memtoreg = 1'b0;
        end
        if (e.exc.ades) begin
            e.ctl.memwrite = 1'b0;
        end
        return e;
    endfunction

    // mul/div model, hi is remainder and lo quotient for a divide
    function automatic logic [63:0] model_hilo(input word_t a, input word_t b,
                                               input logic is_div, input logic sgn);
        longint sa;
        longint sb;
        if (sgn) begin
            sa = longint'($signed(a));
            sb = longint'($signed(b));
        end else begin
            sa = longint'({32'b0, a});
            sb = longint'({32'b0, b});
        end
        if (is_div) begin
            return {word_t'(sa % sb), word_t'(sa / sb)};
        end
        return 64'(sa * sb);
    endfunction

    function automatic issue_t random_issue();
        issue_t ins;
        int     kind;
        ins           = '0;
        ins.valid     = ($urandom % 16) != 0;
        ins.pc        = $urandom & 32'hffff_fffc;
        ins.raw_instr = $urandom;
        ins.rd1       = $urandom;
        ins.rd2       = $urandom;
        ins.pre_b     = $urandom % 2;
        kind          = $urandom % 10;
        case (kind)
            0, 1: begin
                ins.ctl.alu_op   = alu_op_e'(4'($urandom % 14));
                ins.ctl.regwrite = 1'b1;
            end
            2: begin
                ins.ctl.alu_op     = alu_op_e'(4'($urandom % 14));
                ins.ctl.alusrc_imm = 1'b1;
                ins.ctl.zeroext    = $urandom % 2;
                ins.ctl.regwrite   = 1'b1;
            end
            3: begin
                // constant shifts
                ins.ctl.alu_op      = alu_op_e'(4'(SLL + $urandom % 3));
                ins.ctl.shamt_valid = 1'b1;
                ins.ctl.regwrite    = 1'b1;
            end
            4: begin
                ins.ctl.branch      = 1'b1;
                ins.ctl.branch_type = branch_e'(3'($urandom % 6));
                if ($urandom % 2) begin
                    ins.rd2 = ins.rd1;
                end
                if ($urandom % 4 == 0) begin
                    ins.rd1 = '0;
                end
            end
            5, 6: begin
                ins.ctl.jump     = kind == 5;
                ins.ctl.jr       = kind == 6;
                ins.ctl.is_link  = $urandom % 2;
                ins.ctl.regwrite = ins.ctl.is_link;
            end
            7, 8: begin
                ins.ctl.alu_op     = ADDU;
                ins.ctl.alusrc_imm = 1'b1;
                ins.ctl.msize      = msize_e'(2'($urandom % 3));
                ins.ctl.memtoreg   = kind == 7;
                ins.ctl.regwrite   = kind == 7;
                ins.ctl.memwrite   = kind == 8;
                // half the time force a word aligned address
                if ($urandom % 2) begin
                    ins.rd1[1:0] = 2'b00 - ins.raw_instr[1:0];
                end
            end
            default: begin
                ins.ctl.div       = $urandom % 2;
                ins.ctl.mul       = !ins.ctl.div;
                ins.ctl.signed_md = $urandom % 2;
                if ($urandom % 4 == 0) begin
                    ins.rd2 = $urandom % 64;
                end
                // no divide by zero
                if (ins.ctl.div && ins.rd2 == '0) begin
                    ins.rd2 = 32'd1;
                end
            end
        endcase
        return ins;
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic compare_exec(input exec_t exp);
        check_bit("valid", exec_o.valid, exp.valid);
        check_word("pc", exec_o.pc, exp.pc);
        check_word("alu_out", exec_o.alu_out, exp.alu_out);
        check_word("srcb", exec_o.srcb, exp.srcb);
        check_ctl("ctl", exec_o.ctl, exp.ctl);
        check_exc("exc", exec_o.exc, exp.exc);
        check_bit("redirect", exec_o.redirect, exp.redirect);
        // target only matters on a redirect
        if (exp.redirect) begin
            check_word("target", exec_o.target, exp.target);
        end
    endtask

    // issue one instruction and hold it until the stage takes it
    task automatic run_one(input issue_t ins);
        exec_t       exp;
        logic [63:0] exp_hilo;
        logic        is_md;
        logic        done;
        logic        checked;
        int          cycles;
        exp      = model_exec(ins);
        is_md    = ins.valid && (ins.ctl.mul || ins.ctl.div);
        exp_hilo = model_hilo(ins.rd1, ins.rd2, ins.ctl.div, ins.ctl.signed_md);
        done     = 1'b0;
        checked  = 1'b0;
        cycles   = 0;
        @(posedge clk);
        issue_i <= ins;
        stall_i <= ($urandom % 3) == 0;
        @(negedge clk);
        // busy is combinational in the issue cycle
        check_bit("busy_o at issue", busy_o, is_md);
        while (!done) begin
            if (busy_o && checked) begin
                check_bit("busy_o while result held", busy_o, 1'b0);
            end
            if (!busy_o) begin
                if (!checked) begin
                    compare_exec(exp);
                    if (is_md) begin
                        check_hilo("hilo", exec_o.hilo, exp_hilo);
                    end
                    checked = 1'b1;
                end else if (is_md) begin
                    // back-pressure in done, result must stay put
                    check_hilo("held hilo", exec_o.hilo, exp_hilo);
                end
                done = !stall_i;
            end
            if (!done) begin
                cycles++;
                if (cycles > TIMEOUT) begin
                    $display("Timeout: instruction at pc %h was not taken within %0d cycles",
                             ins.pc, TIMEOUT);
                    timeouts++;
                    done = 1'b1;
                end else begin
                    @(posedge clk);
                    stall_i <= ($urandom % 3) == 0;
                    @(negedge clk);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(4100));
        clk        = 1'b0;
        rst_i      = 1'b1;
        stall_i    = 1'b0;
        issue_i    = '0;
        mismatches = 0;
        timeouts   = 0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_bit("busy_o after reset", busy_o, 1'b0);
        check_hilo("hilo after reset", exec_o.hilo, 64'h0);
        // a stuck stage ends the run early
        for (int i = 0; i < NUM_INSTR && timeouts == 0; i++) begin
            run_one(random_issue());
        end
        finish_run();
    end

endmodule

// File: verification/ex_stage_chk.sv
module ex_stage_chk #(
    parameter int MUL_STAGES = 3
) (
    input logic             clk,
    input logic             rst_i,
    input logic             busy_o,
    input pipe_pkg::issue_t issue_i,
    input pipe_pkg::exec_t  exec_o
);

    // unit idle once reset is seen
    a_busy_after_reset: assert property (@(posedge clk) rst_i |=> !busy_o)
        else $error("busy_o high in the cycle after reset");

    // multiply occupies the stage for MUL_STAGES+1 cycles
    a_mul_length: assert property (@(posedge clk) disable iff (rst_i)
        $rose(busy_o) && issue_i.ctl.mul |-> ##(MUL_STAGES + 1) !busy_o)
        else $error("busy_o did not fall after a multiply");

    // divide is 32 iterations plus the issue cycle
    a_div_length: assert property (@(posedge clk) disable iff (rst_i)
        $rose(busy_o) && issue_i.ctl.div |-> ##33 !busy_o)
        else $error("busy_o did not fall after a divide");

    // bubbles never raise exceptions
    a_exc_invalid: assert property (@(posedge clk) disable iff (rst_i)
        !exec_o.valid |-> (exec_o.exc == '0))
        else $error("exception flag set on an invalid instruction");

endmodule

bind ex_stage_top ex_stage_chk #(
    .MUL_STAGES (MUL_STAGES)
) u_chk (
    .clk     (clk),
    .rst_i   (rst_i),
    .busy_o  (busy_o),
    .issue_i (issue_i),
    .exec_o  (exec_o)
);

// File: verilog/ex_stage_top.sv
module ex_stage_top #(
    parameter int MUL_STAGES = 3
) (
    input  logic             clk,
    input  logic             rst_i,
    input  pipe_pkg::issue_t issue_i,
    input  logic             stall_i,
    output pipe_pkg::exec_t  exec_o,
    output logic             busy_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    operands_t   operands;
    word_t       alu_out;
    logic        overflow;
    logic        redirect;
    word_t       target;
    logic [63:0] hilo;
    logic        md_start;

    // only a live mul or div kicks the unit
    assign md_start = issue_i.valid && (issue_i.ctl.mul || issue_i.ctl.div);

    ex_operand_decode u_decode (
        .issue_i    (issue_i),
        .operands_o (operands)
    );

    ex_alu u_alu (
        .a_i        (operands.srca),
        .b_i        (operands.srcb),
        .op_i       (issue_i.ctl.alu_op),
        .result_o   (alu_out),
        .overflow_o (overflow)
    );

    ex_branch_unit u_branch (
        .issue_i    (issue_i),
        .redirect_o (redirect),
        .target_o   (target)
    );

    // mul/div sees raw register values, not the selected operands
    ex_muldiv #(
        .MUL_STAGES (MUL_STAGES)
    ) u_muldiv (
        .clk      (clk),
        .rst_i    (rst_i),
        .start_i  (md_start),
        .is_div_i (issue_i.ctl.div),
        .signed_i (issue_i.ctl.signed_md),
        .stall_i  (stall_i),
        .a_i      (issue_i.rd1),
        .b_i      (issue_i.rd2),
        .busy_o   (busy_o),
        .hilo_o   (hilo)
    );

    ex_result_merge u_merge (
        .issue_i    (issue_i),
        .operands_i (operands),
        .alu_i      (alu_out),
        .overflow_i (overflow),
        .hilo_i     (hilo),
        .redirect_i (redirect),
        .target_i   (target),
        .exec_o     (exec_o)
    );

endmodule

// File: verilog/ex_result_merge.sv
module ex_result_merge (
    input  pipe_pkg::issue_t    issue_i,
    input  pipe_pkg::operands_t operands_i,
    input  isa_pkg::word_t      alu_i,
    input  logic                overflow_i,
    input  logic [63:0]         hilo_i,
    input  logic                redirect_i,
    input  isa_pkg::word_t      target_i,
    output pipe_pkg::exec_t     exec_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t mem_addr;
    logic  misaligned;
    logic  load_mis;
    logic  store_mis;

    // effective address, base plus offset
    assign mem_addr = operands_i.srca + operands_i.srcb;

    // halfwords need bit 0 clear, words both low bits
    assign misaligned = ((issue_i.ctl.msize == MSIZE2) && mem_addr[0])
                     || ((issue_i.ctl.msize == MSIZE4) && (mem_addr[1:0] != 2'b00));

    assign load_mis  = issue_i.valid && issue_i.ctl.memtoreg && misaligned;
    assign store_mis = issue_i.valid && issue_i.ctl.memwrite && misaligned;

    always_comb begin
        exec_o.valid    = issue_i.valid;
        exec_o.pc       = issue_i.pc;
        // link writes the return address past the delay slot
        exec_o.alu_out  = issue_i.ctl.is_link ? issue_i.pc + 32'd8 : alu_i;
        exec_o.srcb     = issue_i.rd2;
        exec_o.ctl      = issue_i.ctl;
        exec_o.hilo     = hilo_i;
        exec_o.redirect = redirect_i;
        exec_o.target   = target_i;
        exec_o.exc.overflow = issue_i.valid && overflow_i;
        exec_o.exc.adel     = load_mis;
        exec_o.exc.ades     = store_mis;
        // faulting access must not reach memory
        if (load_mis) begin
            exec_o.ctl.memtoreg = 1'b0;
        end
        if (store_mis) begin
            exec_o.ctl.memwrite = 1'b0;
        end
    end

endmodule

// File: verilog/ex_muldiv.sv
module ex_muldiv #(
    parameter int MUL_STAGES = 3
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           start_i,
    input  logic           is_div_i,
    input  logic           signed_i,
    input  logic           stall_i,
    input  isa_pkg::word_t a_i,
    input  isa_pkg::word_t b_i,
    output logic           busy_o,
    output logic [63:0]    hilo_o
);
    import isa_pkg::*;

    localparam int CNT_W = 6;
    // last busy cycle index for each operation
    localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(MUL_STAGES - 1);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(31);

    md_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             launch;
    logic             last;

    logic  neg_a;
    logic  neg_b;
    word_t abs_a;
    word_t abs_b;
    logic  is_div_q;
    logic  neg_a_q;
    logic  neg_b_q;

    logic [63:0] prod_q [MUL_STAGES];
    word_t       rem_q;
    word_t       quo_q;
    word_t       dvs_q;
    logic [32:0] trial;
    word_t       rem_nxt;
    word_t       quo_nxt;
    logic [63:0] prod_fix;
    logic [63:0] div_fix;

    // magnitudes, signs are put back at the end
    assign neg_a = signed_i & a_i[31];
    assign neg_b = signed_i & b_i[31];
    assign abs_a = neg_a ? -a_i : a_i;
    assign abs_b = neg_b ? -b_i : b_i;

    // busy already in the issue cycle
    assign launch = (state_q == MD_IDLE) && start_i;
    assign busy_o = launch || (state_q == MD_BUSY);
    assign last   = cnt_q == (is_div_q ? DIV_LAST : MUL_LAST);

    // one restoring step, shift in the next dividend bit
    assign trial   = {rem_q, quo_q[31]} - {1'b0, dvs_q};
    assign rem_nxt = trial[32] ? {rem_q[30:0], quo_q[31]} : trial[31:0];
    assign quo_nxt = {quo_q[30:0], ~trial[32]};

    // product and quotient take xor of signs
    assign prod_fix = (neg_a_q ^ neg_b_q) ? -prod_q[MUL_STAGES-1] : prod_q[MUL_STAGES-1];
    // remainder follows the dividend
    assign div_fix = {neg_a_q ? -rem_nxt : rem_nxt,
                      (neg_a_q ^ neg_b_q) ? -quo_nxt : quo_nxt};

    // sequencer and result register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= MD_IDLE;
            cnt_q   <= '0;
            hilo_o  <= '0;
        end else begin
            case (state_q)
                MD_IDLE: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= MD_BUSY;
                    end
                end
                MD_BUSY: begin
                    if (last) begin
                        state_q <= MD_DONE;
                        hilo_o  <= is_div_q ? div_fix : prod_fix;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                MD_DONE: begin
                    // hold result until downstream takes it
                    if (!stall_i) begin
                        state_q <= MD_IDLE;
                    end
                end
                default: state_q <= MD_IDLE;
            endcase
        end
    end

    // operand capture and divider iteration
    always_ff @(posedge clk) begin
        if (launch) begin
            is_div_q  <= is_div_i;
            neg_a_q   <= neg_a;
            neg_b_q   <= neg_b;
            rem_q     <= '0;
            quo_q     <= abs_a;
            dvs_q     <= abs_b;
            prod_q[0] <= 64'(abs_a) * 64'(abs_b);
        end else if ((state_q == MD_BUSY) && is_div_q) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

    // multiplier pipeline registers
    always_ff @(posedge clk) begin
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

endmodule

// File: verilog/ex_branch_unit.sv
module ex_branch_unit (
    input  pipe_pkg::issue_t issue_i,
    output logic             redirect_o,
    output isa_pkg::word_t   target_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc_plus4;
    word_t offset;
    word_t rd1;
    logic  cond;
    logic  taken;

    assign rd1      = issue_i.rd1;
    assign pc_plus4 = issue_i.pc + 32'd4;
    // word offset, sign extended and scaled to bytes
    assign offset   = {{14{issue_i.raw_instr[15]}}, issue_i.raw_instr[15:0], 2'b00};

    // condition on the register values
    always_comb begin
        case (issue_i.ctl.branch_type)
            BEQ:     cond = rd1 == issue_i.rd2;
            BNE:     cond = rd1 != issue_i.rd2;
            BGEZ:    cond = ~rd1[31];
            BGTZ:    cond = ~rd1[31] && (rd1 != '0);
            BLEZ:    cond = rd1[31] || (rd1 == '0);
            BLTZ:    cond = rd1[31];
            default: cond = 1'b0;
        endcase
    end

    assign taken = issue_i.ctl.branch && cond;

    // target for whichever way the prediction went wrong
    always_comb begin
        target_o = '0;
        if (taken && !issue_i.pre_b) begin
            target_o = pc_plus4 + offset;
        end else if (issue_i.ctl.branch && !cond && issue_i.pre_b) begin
            // fall through past the delay slot
            target_o = issue_i.pc + 32'd8;
        end else if (issue_i.ctl.jr) begin
            target_o = rd1;
        end else if (issue_i.ctl.jump) begin
            // region of the delay slot pc
            target_o = {pc_plus4[31:28], issue_i.raw_instr[25:0], 2'b00};
        end
    end

    // branch mispredict either way, or an unpredicted jump
    assign redirect_o = issue_i.valid
        && ((issue_i.ctl.branch && (cond != issue_i.pre_b))
        || ((issue_i.ctl.jump || issue_i.ctl.jr) && !issue_i.pre_b));

endmodule

// File: verilog/ex_alu.sv
module ex_alu (
    input  isa_pkg::word_t   a_i,
    input  isa_pkg::word_t   b_i,
    input  isa_pkg::alu_op_e op_i,
    output isa_pkg::word_t   result_o,
    output logic             overflow_o
);
    import isa_pkg::*;

    word_t    sum;
    word_t    diff;
    logic [4:0] sh;
    logic     add_ovf;
    logic     sub_ovf;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // shift amount lives in the low bits of a
    assign sh = a_i[4:0];

    // same signs in, other sign out
    assign add_ovf = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
    // signs differ, result lost the sign of a
    assign sub_ovf = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);

    always_comb begin
        unique case (op_i)
            ADD, ADDU: result_o = sum;
            SUB, SUBU: result_o = diff;
            AND:       result_o = a_i & b_i;
            OR:        result_o = a_i | b_i;
            XOR:       result_o = a_i ^ b_i;
            NOR:       result_o = ~(a_i | b_i);
            SLT:       result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            SLTU:      result_o = {31'b0, a_i < b_i};
            // shifts operate on b
            SLL:       result_o = b_i << sh;
            SRL:       result_o = b_i >> sh;
            SRA:       result_o = word_t'($signed(b_i) >>> sh);
            LUI:       result_o = {b_i[15:0], 16'b0};
            default:   result_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (op_i)
            ADD:     overflow_o = add_ovf;
            SUB:     overflow_o = sub_ovf;
            default: overflow_o = 1'b0;
        endcase
    end

endmodule

// File: verilog/ex_operand_decode.sv
module ex_operand_decode (
    input  pipe_pkg::issue_t    issue_i,
    output pipe_pkg::operands_t operands_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [15:0] imm;
    logic [4:0]  shamt;
    word_t       imm_ext;

    // immediate and shift amount fields of the raw word
    assign imm   = issue_i.raw_instr[15:0];
    assign shamt = issue_i.raw_instr[10:6];

    // logical ops want the immediate zero extended
    always_comb begin
        if (issue_i.ctl.zeroext) begin
            imm_ext = {16'b0, imm};
        end else begin
            imm_ext = {{16{imm[15]}}, imm};
        end
    end

    // a side
    // constant shifts take the amount from the instruction
    always_comb begin
        if (issue_i.ctl.shamt_valid) begin
            operands_o.srca = {27'b0, shamt};
        end else begin
            operands_o.srca = issue_i.rd1;
        end
    end

    // b side
    // immediate forms and address generation use imm_ext
    always_comb begin
        if (issue_i.ctl.alusrc_imm) begin
            operands_o.srcb = imm_ext;
        end else begin
            operands_o.srcb = issue_i.rd2;
        end
    end

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // decoded control bits carried with each instruction
    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        // b operand from the immediate field
        logic             alusrc_imm;
        logic             zeroext;
        // a operand from instr[10:6]
        logic             shamt_valid;
        logic             branch;
        isa_pkg::branch_e branch_type;
        logic             jump;
        logic             jr;
        logic             is_link;
        logic             mul;
        logic             div;
        logic             signed_md;
        logic             memtoreg;
        logic             memwrite;
        isa_pkg::msize_e  msize;
        logic             regwrite;
    } ctl_t;

    // instruction as handed over by issue
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t raw_instr;
        // register values, already bypassed
        isa_pkg::word_t rd1;
        isa_pkg::word_t rd2;
        ctl_t           ctl;
        // fetch predicted this one as taken
        logic           pre_b;
    } issue_t;

    // alu operands after source selection
    typedef struct packed {
        isa_pkg::word_t srca;
        isa_pkg::word_t srcb;
    } operands_t;

    typedef struct packed {
        logic overflow;
        // address error on load
        logic adel;
        // address error on store
        logic ades;
    } exc_t;

    // execute stage result towards memory
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t alu_out;
        // store data
        isa_pkg::word_t srcb;
        ctl_t           ctl;
        logic [63:0]    hilo;
        logic           redirect;
        isa_pkg::word_t target;
        exc_t           exc;
    } exec_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

    // basic data word of the integer datapath
    typedef logic [31:0] word_t;

    // alu function select
    // the U forms never raise overflow
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        ADDU = 4'd1,
        SUB  = 4'd2,
        SUBU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        SLL  = 4'd10,
        SRL  = 4'd11,
        SRA  = 4'd12,
        LUI  = 4'd13
    } alu_op_e;

    // conditional branch kinds, compared on rd1 and rd2
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BGEZ = 3'd2,
        BGTZ = 3'd3,
        BLEZ = 3'd4,
        BLTZ = 3'd5
    } branch_e;

    // load/store access width in bytes
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2
    } msize_e;

    // multicycle mul/div sequencing
    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_BUSY = 2'd1,
        MD_DONE = 2'd2
    } md_state_e;

endpackage
